/* logic/mover_macros.svh */
`ifndef MOVER_MACROS_SVH
`define MOVER_MACROS_SVH

// Number of channels the sequencer can walk in one transfer
`define MOVER_MAX_CHANNELS 4

// Width of one data word returned by the source
`define MOVER_DATA_WIDTH 32

// Credits the output port holds right after reset
`define MOVER_CREDITS 2

// One count register, then one address register and one user register per channel
`define MOVER_REG_COUNT (1 + 2 * `MOVER_MAX_CHANNELS)
`define MOVER_REG_USER_BASE 5

`endif

/* logic/mover_config_pkg.sv */
`include "mover_macros.svh"

package mover_config_pkg;

    // Address on the host register port
    typedef logic [7:0] reg_address_t;

    // Contents of one register in the bank
    typedef logic [31:0] reg_data_t;

    // Selects one of the channels
    typedef logic [1:0] channel_index_t;

    // Number of active channels, 0 up to the maximum inclusive
    typedef logic [2:0] channel_count_t;

endpackage

/* logic/mover_stream_pkg.sv */
`include "mover_macros.svh"

package mover_stream_pkg;

    // Word carried from the source to the output stream
    typedef logic [`MOVER_DATA_WIDTH-1:0] data_word_t;

    // Per-channel fields decoded from the register bank
    typedef logic [15:0] source_address_t;
    typedef logic [15:0] dest_tag_t;
    typedef logic [15:0] user_value_t;

    // States of the channel-walking sequencer
    typedef enum logic [2:0] {
        idle,
        read_source,
        wait_response,
        send_buffered,
        wait_space
    } sequencer_state_t;

    // Credits on the output link, never more than the reset value
    typedef logic [1:0] credit_count_t;

endpackage

/* logic/channel_config_if.sv */
`timescale 1ns/1ns
`include "mover_macros.svh"

interface channel_config_if;
    import mover_config_pkg::*;
    import mover_stream_pkg::*;

    // Decoded settings, stable between register writes
    channel_count_t channel_count;
    source_address_t source_address [`MOVER_MAX_CHANNELS];
    dest_tag_t dest_tag [`MOVER_MAX_CHANNELS];
    user_value_t user_value [`MOVER_MAX_CHANNELS];

    // The register file drives the fields
    modport provider (output channel_count, source_address, dest_tag, user_value);

    // The sequencer only reads them
    modport consumer (input channel_count, source_address, dest_tag, user_value);

endinterface

/* logic/mover_stream_if.sv */
`timescale 1ns/1ns

interface mover_stream_if;
    import mover_stream_pkg::*;

    // One word is enqueued in every cycle where valid is high
    logic valid;
    data_word_t data;
    dest_tag_t dest;
    user_value_t user;

    // High while the output queue can take another word
    logic space;

    // The sequencer offers words and watches space
    modport sender (output valid, data, dest, user, input space);

    // The output port takes words and reports space
    modport receiver (input valid, data, dest, user, output space);

endinterface

/* logic/channel_register_file.sv */
`timescale 1ns/1ns
`include "mover_macros.svh"

module channel_register_file (
    input logic clock,
    input logic reset,
    input logic reg_write,
    input mover_config_pkg::reg_address_t reg_address,
    input mover_config_pkg::reg_data_t reg_write_data,
    output mover_config_pkg::reg_data_t reg_read_data,
    channel_config_if.provider config_bus
);
    import mover_config_pkg::*;

    // Enough address bits to reach every register in the bank
    localparam int index_width = $clog2(`MOVER_REG_COUNT);

    // Register 0 is the channel count
    // Registers 1 to 4 hold source and destination per channel
    // Registers 5 to 8 hold the user values
    reg_data_t registers [`MOVER_REG_COUNT];

    logic address_in_map;
    logic [index_width-1:0] register_index;

    // Anything past the last register is outside the map
    assign address_in_map = reg_address < reg_address_t'(`MOVER_REG_COUNT);
    assign register_index = reg_address[index_width-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int k = 0; k < `MOVER_REG_COUNT; k++) begin
                registers[k] <= '0;
            end
        end else if (reg_write && address_in_map) begin
            if (register_index == '0) begin
                // A count above the channel limit is stored as the limit
                if (reg_write_data > reg_data_t'(`MOVER_MAX_CHANNELS)) begin
                    registers[0] <= reg_data_t'(`MOVER_MAX_CHANNELS);
                end else begin
                    registers[0] <= reg_write_data;
                end
            end else begin
                registers[register_index] <= reg_write_data;
            end
        end
    end

    // Read-back follows the address in the same cycle
    always_comb begin
        if (address_in_map) begin
            reg_read_data = registers[register_index];
        end else begin
            reg_read_data = '0;
        end
    end

    // Split the bank into per-channel fields for the sequencer
    always_comb begin
        // The clamp on write keeps the count within three bits
        config_bus.channel_count = registers[0][2:0];
        for (int n = 0; n < `MOVER_MAX_CHANNELS; n++) begin
            config_bus.source_address[n] = registers[n + 1][15:0];
            config_bus.dest_tag[n] = registers[n + 1][31:16];
            // Upper half of a user register is storage only
            config_bus.user_value[n] = registers[`MOVER_REG_USER_BASE + n][15:0];
        end
    end

endmodule

/* logic/transfer_sequencer.sv */
`timescale 1ns/1ns
`include "mover_macros.svh"

module transfer_sequencer (
    input logic clock,
    input logic reset,
    input logic start,
    input logic repeat_outputs,
    output logic done,
    output logic request_valid,
    output mover_stream_pkg::source_address_t request_address,
    input logic response_valid,
    input mover_stream_pkg::data_word_t response_data,
    channel_config_if.consumer config_bus,
    mover_stream_if.sender stream
);
    import mover_config_pkg::*;
    import mover_stream_pkg::*;

    sequencer_state_t state;
    channel_index_t channel;

    // Set while the buffers are being replayed instead of read from the source
    logic replaying;

    // Last word received for each channel
    data_word_t buffers [`MOVER_MAX_CHANNELS];

    logic last_channel;
    logic no_channels;

    assign last_channel = (channel_count_t'(channel) + channel_count_t'(1))
        == config_bus.channel_count;
    assign no_channels = config_bus.channel_count == '0;

    // Words go to the queue in the same cycle they are offered
    // A request is only sent while space is high, and nothing else fills the
    // queue until its response comes back, so the response always fits
    always_comb begin
        stream.valid = 1'b0;
        stream.data = buffers[channel];
        stream.dest = config_bus.dest_tag[channel];
        stream.user = config_bus.user_value[channel];
        if (state == wait_response) begin
            stream.valid = response_valid;
            stream.data = response_data;
        end else if (state == send_buffered) begin
            stream.valid = stream.space;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            channel <= '0;
            replaying <= 1'b0;
            done <= 1'b0;
            request_valid <= 1'b0;
            // A channel that was never read replays as zero
            for (int n = 0; n < `MOVER_MAX_CHANNELS; n++) begin
                buffers[n] <= '0;
            end
        end else begin
            done <= 1'b0;
            request_valid <= 1'b0;
            case (state)
                idle: begin
                    channel <= '0;
                    if (start || repeat_outputs) begin
                        replaying <= !start;
                        if (no_channels) begin
                            // Nothing to move, so finish straight away
                            done <= 1'b1;
                        end else if (!start) begin
                            state <= send_buffered;
                        end else if (stream.space) begin
                            request_valid <= 1'b1;
                            request_address <= config_bus.source_address[0];
                            state <= wait_response;
                        end else begin
                            state <= wait_space;
                        end
                    end
                end
                read_source: begin
                    if (stream.space) begin
                        request_valid <= 1'b1;
                        request_address <= config_bus.source_address[channel];
                        state <= wait_response;
                    end else begin
                        state <= wait_space;
                    end
                end
                wait_response: begin
                    if (response_valid) begin
                        // The word was enqueued this cycle, keep a copy for repeats
                        buffers[channel] <= response_data;
                        if (last_channel) begin
                            done <= 1'b1;
                            state <= idle;
                        end else begin
                            channel <= channel + 2'd1;
                            state <= read_source;
                        end
                    end
                end
                send_buffered: begin
                    if (!stream.space) begin
                        state <= wait_space;
                    end else if (last_channel) begin
                        done <= 1'b1;
                        state <= idle;
                    end else begin
                        channel <= channel + 2'd1;
                    end
                end
                wait_space: begin
                    // Resume whichever walk was held up
                    if (stream.space) begin
                        state <= replaying ? send_buffered : read_source;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* logic/credit_output_port.sv */
`timescale 1ns/1ns
`include "mover_macros.svh"

module credit_output_port (
    input logic clock,
    input logic reset,
    mover_stream_if.receiver stream,
    input logic credit_return,
    output logic out_valid,
    output mover_stream_pkg::data_word_t out_data,
    output mover_stream_pkg::dest_tag_t out_dest,
    output mover_stream_pkg::user_value_t out_user
);
    import mover_stream_pkg::*;

    localparam int queue_depth = 2;

    // Queue storage, one slot per pointer value
    data_word_t queue_data [queue_depth];
    dest_tag_t queue_dest [queue_depth];
    user_value_t queue_user [queue_depth];

    logic write_pointer;
    logic read_pointer;
    logic [1:0] fill;
    credit_count_t credits;

    logic enqueue;
    logic send;

    assign enqueue = stream.valid;

    // The head word leaves whenever the receiver still has a credit for it
    assign send = (fill != 2'd0) && (credits != '0);

    assign stream.space = fill != 2'(queue_depth);

    assign out_valid = send;
    assign out_data = queue_data[read_pointer];
    assign out_dest = queue_dest[read_pointer];
    assign out_user = queue_user[read_pointer];

    always_ff @(posedge clock) begin
        if (enqueue) begin
            queue_data[write_pointer] <= stream.data;
            queue_dest[write_pointer] <= stream.dest;
            queue_user[write_pointer] <= stream.user;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_pointer <= 1'b0;
            read_pointer <= 1'b0;
            fill <= '0;
            credits <= credit_count_t'(`MOVER_CREDITS);
        end else begin
            if (enqueue) begin
                write_pointer <= !write_pointer;
            end
            if (send) begin
                read_pointer <= !read_pointer;
            end
            // Enqueue and send in the same cycle leave the fill level alone
            case ({enqueue, send})
                2'b10: fill <= fill + 2'd1;
                2'b01: fill <= fill - 2'd1;
                default: fill <= fill;
            endcase
            // A returned credit and a spent one cancel out
            case ({credit_return, send})
                2'b10: credits <= credits + 2'd1;
                2'b01: credits <= credits - 2'd1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* logic/data_mover_top.sv */
`timescale 1ns/1ns

module data_mover_top (
    input logic clock,
    input logic reset,
    input logic reg_write,
    input mover_config_pkg::reg_address_t reg_address,
    input mover_config_pkg::reg_data_t reg_write_data,
    output mover_config_pkg::reg_data_t reg_read_data,
    input logic start,
    input logic repeat_outputs,
    output logic done,
    output logic request_valid,
    output mover_stream_pkg::source_address_t request_address,
    input logic response_valid,
    input mover_stream_pkg::data_word_t response_data,
    input logic credit_return,
    output logic out_valid,
    output mover_stream_pkg::data_word_t out_data,
    output mover_stream_pkg::dest_tag_t out_dest,
    output mover_stream_pkg::user_value_t out_user
);

    // Decoded channel settings
    channel_config_if config_bus ();

    // Words on their way to the credit port
    mover_stream_if stream ();

    channel_register_file u_register_file (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_write_data(reg_write_data),
        .reg_read_data(reg_read_data),
        .config_bus(config_bus.provider)
    );

    transfer_sequencer u_sequencer (
        .clock(clock),
        .reset(reset),
        .start(start),
        .repeat_outputs(repeat_outputs),
        .done(done),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data),
        .config_bus(config_bus.consumer),
        .stream(stream.sender)
    );

    credit_output_port u_output_port (
        .clock(clock),
        .reset(reset),
        .stream(stream.receiver),
        .credit_return(credit_return),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user)
    );

endmodule

/* testbench/data_source_model.sv */
`timescale 1ns/1ns

module data_source_model (
    input logic clock,
    input logic reset,
    input logic request_valid,
    input mover_stream_pkg::source_address_t request_address,
    output logic response_valid,
    output mover_stream_pkg::data_word_t response_data
);
    import mover_stream_pkg::*;

    logic [31:0] lfsr_state;

    // Fibonacci LFSR for x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    initial begin
        source_address_t address;
        int delay;
        response_valid = 1'b0;
        response_data = '0;
        lfsr_state = 32'hd89;
        forever begin
            // Requests are registered, so mid-cycle is a safe place to look
            @(negedge clock);
            if (reset && request_valid) begin
                address = request_address;
                // Two LFSR bits give an extra wait of 0 to 3 cycles
                delay = 1;
                for (int b = 0; b < 2; b++) begin
                    lfsr_state = lfsr_step(lfsr_state);
                    delay = delay + (int'(lfsr_state[0]) << b);
                end
                repeat (delay) @(posedge clock);
                #5;
                response_valid = 1'b1;
                response_data = (data_word_t'(address) * 32'd65537) ^ 32'h5a5a0000;
                @(posedge clock);
                #5;
                response_valid = 1'b0;
                response_data = '0;
            end
        end
    end

endmodule

/* testbench/data_mover_tb.sv */
`timescale 1ns/1ns
`include "mover_macros.svh"

module data_mover_tb;
    import mover_config_pkg::*;
    import mover_stream_pkg::*;

    localparam int timeout_cycles = 200;

    logic clock = 1'b0;
    logic reset;
    logic reg_write;
    reg_address_t reg_address;
    reg_data_t reg_write_data;
    reg_data_t reg_read_data;
    logic start;
    logic repeat_outputs;
    logic done;
    logic request_valid;
    source_address_t request_address;
    logic response_valid;
    data_word_t response_data;
    logic credit_return = 1'b0;
    logic out_valid;
    data_word_t out_data;
    dest_tag_t out_dest;
    user_value_t out_user;

    // Scoreboard state shared by the sink, the credit return and the stimulus
    string test_name = "reset state";
    logic withhold_credits = 1'b0;
    int words_received = 0;
    int credits_returned = 0;
    int done_count = 0;
    source_address_t expected_requests [$];
    // Packed as data, dest, user from the top down
    logic [63:0] expected_words [$];
    logic [63:0] last_transfer [$];

    always #50 clock = ~clock;

    data_mover_top u_dut (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_write_data(reg_write_data),
        .reg_read_data(reg_read_data),
        .start(start),
        .repeat_outputs(repeat_outputs),
        .done(done),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data),
        .credit_return(credit_return),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_dest(out_dest),
        .out_user(out_user)
    );

    data_source_model u_source (
        .clock(clock),
        .reset(reset),
        .request_valid(request_valid),
        .request_address(request_address),
        .response_valid(response_valid),
        .response_data(response_data)
    );

    // The source answers with the address repeated in both halves, then scrambled
    function automatic data_word_t source_word(input source_address_t address);
        return (data_word_t'(address) * 32'd65537) ^ 32'h5a5a0000;
    endfunction

    task automatic stop_on_mismatch(input string what, input logic [31:0] expected,
                                    input logic [31:0] actual);
        $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first wrong value");
    endtask

    task automatic stop_with_message(input string message);
        $display("%s during %s", message, test_name);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    // The sink and the protocol watch sample mid-cycle where every output has settled
    always @(negedge clock) begin
        logic [63:0] expected;
        int usable_credits;
        if (!reset) begin
            assert (!out_valid && !request_valid && !done)
                else stop_with_message("outputs active while reset is held");
        end else begin
            // A credit on the wire this cycle is not yet in the DUT counter
            usable_credits = `MOVER_CREDITS - words_received + credits_returned
                - int'(credit_return);
            if (request_valid) begin
                assert (expected_requests.size() > 0)
                    else stop_with_message("source request when none was expected");
                assert (request_address == expected_requests[0])
                    else stop_on_mismatch("request_address", 32'(expected_requests[0]),
                                          32'(request_address));
                void'(expected_requests.pop_front());
            end
            if (done) begin
                done_count++;
                assert (expected_requests.size() == 0)
                    else stop_with_message("done before every request was issued");
            end
            if (out_valid) begin
                assert (usable_credits > 0)
                    else stop_with_message("out_valid while no credit was held");
                assert (expected_words.size() > 0)
                    else stop_with_message("output word when none was expected");
                expected = expected_words.pop_front();
                assert (out_data == expected[63:32])
                    else stop_on_mismatch("out_data", expected[63:32], out_data);
                assert (out_dest == expected[31:16])
                    else stop_on_mismatch("out_dest", 32'(expected[31:16]), 32'(out_dest));
                assert (out_user == expected[15:0])
                    else stop_on_mismatch("out_user", 32'(expected[15:0]), 32'(out_user));
                words_received++;
            end
        end
    end

    // One credit goes back per cycle for each word taken, unless held off
    always @(posedge clock) begin
        #5;
        if (!withhold_credits && words_received > credits_returned) begin
            credit_return = 1'b1;
            credits_returned++;
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic write_register(input int address, input reg_data_t value);
        reg_write = 1'b1;
        reg_address = reg_address_t'(address);
        reg_write_data = value;
        next_cycle();
        reg_write = 1'b0;
    endtask

    task automatic check_register(input int address, input reg_data_t expected);
        reg_address = reg_address_t'(address);
        @(negedge clock);
        assert (reg_read_data == expected)
            else stop_on_mismatch($sformatf("register %0d", address), expected, reg_read_data);
        next_cycle();
    endtask

    // Fills every channel and queues what the active ones should produce
    task automatic program_transfer(input int count, input int base);
        source_address_t address;
        dest_tag_t dest;
        user_value_t user;
        last_transfer.delete();
        write_register(0, reg_data_t'(count));
        for (int n = 0; n < `MOVER_MAX_CHANNELS; n++) begin
            address = source_address_t'(base + 'h0101 * n);
            dest = dest_tag_t'('hd000 + base + n);
            user = user_value_t'('h7c00 + 3 * n + base);
            write_register(n + 1, {dest, address});
            // Upper half of the user register must not reach the stream
            write_register(`MOVER_REG_USER_BASE + n, {16'h00a5, user});
            if (n < count) begin
                expected_requests.push_back(address);
                last_transfer.push_back({source_word(address), dest, user});
            end
        end
    endtask

    task automatic pulse_control(input logic use_repeat);
        start = !use_repeat;
        repeat_outputs = use_repeat;
        next_cycle();
        start = 1'b0;
        repeat_outputs = 1'b0;
    endtask

    task automatic wait_for_words(input int target);
        int cycles;
        cycles = 0;
        while (words_received < target) begin
            next_cycle();
            cycles++;
            if (cycles > timeout_cycles) stop_with_message("timed out waiting for output words");
        end
    endtask

    task automatic wait_for_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target) begin
            next_cycle();
            cycles++;
            if (cycles > timeout_cycles) stop_with_message("timed out waiting for done");
        end
    endtask

    task automatic wait_for_credits();
        int cycles;
        cycles = 0;
        while (credits_returned < words_received) begin
            next_cycle();
            cycles++;
            if (cycles > timeout_cycles) stop_with_message("timed out returning credits");
        end
    endtask

    // Starts a walk or a replay and checks the counts once the port is idle again
    task automatic run_transfer(input logic use_repeat, input int words);
        int done_before;
        int words_before;
        done_before = done_count;
        words_before = words_received;
        foreach (last_transfer[i]) expected_words.push_back(last_transfer[i]);
        pulse_control(use_repeat);
        wait_for_done(done_before + 1);
        wait_for_words(words_before + words);
        wait_for_credits();
        // A short quiet window catches a late second done or stray word
        repeat (5) next_cycle();
        assert (done_count == done_before + 1)
            else stop_on_mismatch("done pulses", 32'(done_before + 1), 32'(done_count));
    endtask

    initial begin
        int done_before;
        int words_before;
        reset = 1'b0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        start = 1'b0;
        repeat_outputs = 1'b0;
        repeat (8) next_cycle();
        reset = 1'b1;
        @(negedge clock);
        assert (!out_valid && !request_valid && !done)
            else stop_with_message("outputs active right after reset");
        next_cycle();
        for (int k = 0; k < `MOVER_REG_COUNT; k++) check_register(k, '0);

        test_name = "register readback";
        write_register(0, 32'd7);
        check_register(0, 32'd4);
        write_register(2, 32'hbeef_1234);
        check_register(2, 32'hbeef_1234);
        write_register(8, 32'h1357_9bdf);
        check_register(8, 32'h1357_9bdf);
        write_register(9, 32'hffff_ffff);
        check_register(9, '0);
        check_register(200, '0);

        test_name = "full transfer";
        program_transfer(3, 'h0040);
        run_transfer(1'b0, 3);

        test_name = "credit back-pressure";
        program_transfer(4, 'h0300);
        foreach (last_transfer[i]) expected_words.push_back(last_transfer[i]);
        withhold_credits = 1'b1;
        done_before = done_count;
        words_before = words_received;
        pulse_control(1'b0);
        wait_for_words(words_before + `MOVER_CREDITS);
        wait_for_done(done_before + 1);
        repeat (20) next_cycle();
        assert (words_received == words_before + `MOVER_CREDITS)
            else stop_on_mismatch("words without credit", 32'(words_before + `MOVER_CREDITS),
                                  32'(words_received));
        withhold_credits = 1'b0;
        wait_for_words(words_before + 4);
        wait_for_credits();
        assert (done_count == done_before + 1)
            else stop_on_mismatch("done pulses", 32'(done_before + 1), 32'(done_count));

        // Buffers still hold the back-pressure transfer
        test_name = "repeat";
        run_transfer(1'b1, 4);

        test_name = "zero channels";
        program_transfer(0, 'h0500);
        run_transfer(1'b0, 0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/mover_config_pkg.sv
logic/mover_stream_pkg.sv
logic/channel_config_if.sv
logic/mover_stream_if.sv
logic/channel_register_file.sv
logic/transfer_sequencer.sv
logic/credit_output_port.sv
logic/data_mover_top.sv
testbench/data_source_model.sv
testbench/data_mover_tb.sv

/* Makefile */
# Verilator build and run of the data mover testbench
VERILATOR ?= verilator
TOP ?= data_mover_tb
FILELIST ?= verilog.f
FLAGS ?= --binary --timing --assert -j 0
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST FLAGS BUILD_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
